//--- logic/decodePkg.sv
`default_nettype none

package decodePkg;

	typedef logic [31:0] word_t;	// PC, instruction, immediate
	typedef logic [4:0]  regIdx_t;
	typedef logic [3:0]  aluFn_t;	// {instr[30], funct3} coding
	typedef logic [3:0]  memOp_t;	// {store, unsigned, size}, zero is no access

	// RV32 major opcodes
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_OPIMM  = 7'b0010011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE} immFmt_t;

	typedef enum logic [2:0] {FU_ALU, FU_MULDIV, FU_LSU, FU_BRANCH, FU_CSR} fnUnit_t;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_TRAP} pcSel_t;

	typedef enum logic {IDLE, HOLD} stallState_t;

	// ALU codes that are not taken straight from funct3
	localparam aluFn_t ALU_ADD  = 4'b0000;
	localparam aluFn_t ALU_SUB  = 4'b1000;
	localparam aluFn_t ALU_SLT  = 4'b0010;
	localparam aluFn_t ALU_SLTU = 4'b0011;

	// Size 01 byte, 10 half, 11 word
	localparam memOp_t MEM_NONE = 4'b0000;
	localparam memOp_t MEM_LB   = 4'b0001;
	localparam memOp_t MEM_LH   = 4'b0010;
	localparam memOp_t MEM_LW   = 4'b0011;
	localparam memOp_t MEM_LBU  = 4'b0101;
	localparam memOp_t MEM_LHU  = 4'b0110;
	localparam memOp_t MEM_SB   = 4'b1001;
	localparam memOp_t MEM_SH   = 4'b1010;
	localparam memOp_t MEM_SW   = 4'b1011;

	localparam logic [1:0] BSEL_REG  = 2'd0;	// rs2
	localparam logic [1:0] BSEL_IMM  = 2'd1;
	localparam logic [1:0] BSEL_FOUR = 2'd2;	// Link address pc+4

	localparam logic [6:0]  F7_BASE   = 7'h00;
	localparam logic [6:0]  F7_ALT    = 7'h20;	// SUB, SRA
	localparam logic [6:0]  F7_MULDIV = 7'h01;
	localparam logic [11:0] F12_ECALL = 12'h000;
	localparam logic [11:0] F12_MRET  = 12'h302;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
		logic  misaligned;	// Raised by fetch
	} fetchPkt_t;

	typedef struct packed {
		logic        valid;
		word_t       pc;
		regIdx_t     rd;
		regIdx_t     rs1;
		regIdx_t     rs2;
		word_t       imm;
		aluFn_t      aluFn;
		fnUnit_t     fnUnit;
		logic [1:0]  bSel;
		memOp_t      memOp;
		logic [2:0]  mulDivOp;	// funct3 of the M extension
		pcSel_t      pcSel;
		logic        we;
		logic        branch;
		logic        branchNe;	// Invert compare result
		logic        jump;
		logic        jumpReg;	// JALR
		logic        lui;
		logic        auipc;
		logic [11:0] csrAddr;
		logic [2:0]  funct3;
		logic        misaligned;
		logic        ecall;
		logic        mret;
		logic        system;
		logic        illegal;
	} decodeOut_t;

endpackage

`default_nettype wire

//--- logic/holdTimer.sv
`timescale 1ns/1ns
`default_nettype none

module holdTimer (
	input  logic       clk,
	input  logic       nrst,
	input  logic       load,	// From stallCtrl on entry to HOLD
	input  logic [1:0] loadValue,
	output logic       done
);

	logic [1:0] count;	// Hold cycles still to run

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			count <= 2'd0;
		else if (load)
			count <= loadValue;
		else if (count != 2'd0)
			count <= count - 2'd1;	// Stops at zero
	end

	// Last cycle of the hold, or idle
	assign done = (count <= 2'd1);

	// A zero load would end the hold before it starts
	assert property (@(posedge clk) disable iff (!nrst) load |-> loadValue != 2'd0)
		else $error("holdTimer: load with zero count");

endmodule

`default_nettype wire

//--- logic/stallCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module stallCtrl (
	input  logic       clk,
	input  logic       nrst,
	input  logic       stallReq,	// One-cycle pulse from scoreboard
	input  logic [1:0] stallCycles,	// 1 to 3
	input  logic       timerDone,
	output logic       timerLoad,
	output logic [1:0] timerValue,
	output logic       hold
);

	decodePkg::stallState_t state;
	decodePkg::stallState_t nextState;
	logic                   startReq;	// Request accepted this cycle

	assign startReq = (state == decodePkg::IDLE) && stallReq;

	// Timer covers the hold cycles after this one
	assign timerLoad  = startReq && (stallCycles > 2'd1);
	assign timerValue = stallCycles - 2'd1;

	assign hold = startReq || (state == decodePkg::HOLD);

	always_comb
	begin
		nextState = state;
		case (state)
			decodePkg::IDLE:
				if (timerLoad)
					nextState = decodePkg::HOLD;
			decodePkg::HOLD:
				if (timerDone)
					nextState = decodePkg::IDLE;	// Requests in HOLD are dropped
			default:
				nextState = decodePkg::IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= decodePkg::IDLE;
		else
			state <= nextState;
	end

	assert property (@(posedge clk) disable iff (!nrst) stallReq |-> stallCycles != 2'd0)
		else $error("stallCtrl: stall request with zero cycles");

	// Timer must have taken the count on the edge into HOLD
	assert property (@(posedge clk) disable iff (!nrst)
		$rose(state == decodePkg::HOLD) |-> timerDone == ($past(timerValue) == 2'd1))
		else $error("stallCtrl: HOLD without a running timer");

endmodule

`default_nettype wire

//--- logic/immGen.sv
`timescale 1ns/1ns
`default_nettype none

module immGen (
	input  decodePkg::word_t   instr,
	input  decodePkg::immFmt_t fmt,
	output decodePkg::word_t   imm
);

	logic sign;	// Every format extends from bit 31

	assign sign = instr[31];

	always_comb
	begin
		case (fmt)
			decodePkg::FMT_I:
				imm = {{20{sign}}, instr[31:20]};	// Loads, ALU imm, JALR
			decodePkg::FMT_S:
				imm = {{20{sign}}, instr[31:25], instr[11:7]};
			decodePkg::FMT_B:
				imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			decodePkg::FMT_U:
				imm = {instr[31:12], 12'b0};
			decodePkg::FMT_J:
				imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = '0;	// FMT_NONE
		endcase
	end

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input  decodePkg::word_t      instr,
	input  logic                  exceptionPending,	// Turns the slot into a bubble
	output decodePkg::decodeOut_t ctrl,
	output decodePkg::immFmt_t    fmt
);

	decodePkg::opcode_t opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	logic [11:0]        funct12;

	assign opcode  = decodePkg::opcode_t'(instr[6:0]);
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign funct12 = instr[31:20];

	always_comb
	begin
		// Operand and packet fields stay zero here
		ctrl        = '0;
		ctrl.aluFn  = decodePkg::ALU_ADD;
		ctrl.fnUnit = decodePkg::FU_ALU;
		ctrl.bSel   = decodePkg::BSEL_REG;
		ctrl.memOp  = decodePkg::MEM_NONE;
		ctrl.pcSel  = decodePkg::PC_SEQ;
		ctrl.funct3 = funct3;
		fmt         = decodePkg::FMT_NONE;

		case (opcode)
			decodePkg::OPC_LOAD:
			begin
				fmt         = decodePkg::FMT_I;
				ctrl.fnUnit = decodePkg::FU_LSU;
				ctrl.bSel   = decodePkg::BSEL_IMM;	// Address rs1 + imm
				ctrl.we     = 1'b1;
				case (funct3)
					3'b000:  ctrl.memOp = decodePkg::MEM_LB;
					3'b001:  ctrl.memOp = decodePkg::MEM_LH;
					3'b010:  ctrl.memOp = decodePkg::MEM_LW;
					3'b100:  ctrl.memOp = decodePkg::MEM_LBU;
					3'b101:  ctrl.memOp = decodePkg::MEM_LHU;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			decodePkg::OPC_STORE:
			begin
				fmt         = decodePkg::FMT_S;
				ctrl.fnUnit = decodePkg::FU_LSU;
				ctrl.bSel   = decodePkg::BSEL_IMM;
				case (funct3)
					3'b000:  ctrl.memOp = decodePkg::MEM_SB;
					3'b001:  ctrl.memOp = decodePkg::MEM_SH;
					3'b010:  ctrl.memOp = decodePkg::MEM_SW;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			decodePkg::OPC_OPIMM:
			begin
				fmt        = decodePkg::FMT_I;
				ctrl.bSel  = decodePkg::BSEL_IMM;
				ctrl.we    = 1'b1;
				ctrl.aluFn = {1'b0, funct3};
				// Shift immediates carry funct7 in the upper imm bits
				if (funct3 == 3'b001 && funct7 != decodePkg::F7_BASE)
					ctrl.illegal = 1'b1;
				else if (funct3 == 3'b101)
				begin
					ctrl.aluFn = {instr[30], funct3};	// SRAI or SRLI
					if (funct7 != decodePkg::F7_BASE && funct7 != decodePkg::F7_ALT)
						ctrl.illegal = 1'b1;
				end
			end
			decodePkg::OPC_OP:
			begin
				ctrl.we    = 1'b1;
				ctrl.aluFn = {instr[30], funct3};
				if (funct7 == decodePkg::F7_MULDIV)
				begin
					ctrl.fnUnit   = decodePkg::FU_MULDIV;
					ctrl.mulDivOp = funct3;
				end
				else if (funct7 == decodePkg::F7_ALT)
				begin
					if (funct3 != 3'b000 && funct3 != 3'b101)
						ctrl.illegal = 1'b1;	// Only SUB and SRA
				end
				else if (funct7 != decodePkg::F7_BASE)
					ctrl.illegal = 1'b1;
			end
			decodePkg::OPC_BRANCH:
			begin
				fmt           = decodePkg::FMT_B;
				ctrl.fnUnit   = decodePkg::FU_BRANCH;
				ctrl.branch   = 1'b1;
				ctrl.pcSel    = decodePkg::PC_BRANCH;
				ctrl.branchNe = funct3[0];	// BNE, BGE, BGEU
				case (funct3[2:1])
					2'b00:   ctrl.aluFn = decodePkg::ALU_SUB;
					2'b10:   ctrl.aluFn = decodePkg::ALU_SLT;
					2'b11:   ctrl.aluFn = decodePkg::ALU_SLTU;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			decodePkg::OPC_JAL:
			begin
				fmt         = decodePkg::FMT_J;
				ctrl.fnUnit = decodePkg::FU_BRANCH;
				ctrl.jump   = 1'b1;
				ctrl.pcSel  = decodePkg::PC_JUMP;
				ctrl.bSel   = decodePkg::BSEL_FOUR;
				ctrl.we     = 1'b1;
			end
			decodePkg::OPC_JALR:
			begin
				fmt          = decodePkg::FMT_I;
				ctrl.fnUnit  = decodePkg::FU_BRANCH;
				ctrl.jump    = 1'b1;
				ctrl.jumpReg = 1'b1;
				ctrl.pcSel   = decodePkg::PC_JUMP;
				ctrl.bSel    = decodePkg::BSEL_FOUR;
				ctrl.we      = 1'b1;
				ctrl.illegal = (funct3 != 3'b000);
			end
			decodePkg::OPC_LUI:
			begin
				fmt       = decodePkg::FMT_U;
				ctrl.lui  = 1'b1;
				ctrl.bSel = decodePkg::BSEL_IMM;
				ctrl.we   = 1'b1;
			end
			decodePkg::OPC_AUIPC:
			begin
				fmt        = decodePkg::FMT_U;
				ctrl.auipc = 1'b1;	// Operand A from pc
				ctrl.bSel  = decodePkg::BSEL_IMM;
				ctrl.we    = 1'b1;
			end
			decodePkg::OPC_SYSTEM:
			begin
				ctrl.system = 1'b1;
				ctrl.fnUnit = decodePkg::FU_CSR;
				if (funct3 == 3'b000)
				begin
					ctrl.pcSel = decodePkg::PC_TRAP;	// Redirect via trap logic
					if (funct12 == decodePkg::F12_ECALL)
						ctrl.ecall = 1'b1;
					else if (funct12 == decodePkg::F12_MRET)
						ctrl.mret = 1'b1;
					else
						ctrl.illegal = 1'b1;
				end
				else if (funct3 == 3'b100)
					ctrl.illegal = 1'b1;
				else
					ctrl.we = 1'b1;	// CSR ops return the old value
			end
			default:
				ctrl.illegal = 1'b1;	// Unknown opcode
		endcase

		if (ctrl.illegal)
			ctrl.we = 1'b0;

		// Bubble while commit drains a trap
		if (exceptionPending)
		begin
			ctrl.we      = 1'b0;
			ctrl.memOp   = decodePkg::MEM_NONE;
			ctrl.fnUnit  = decodePkg::FU_ALU;
			ctrl.pcSel   = decodePkg::PC_SEQ;
			ctrl.system  = 1'b0;
			ctrl.ecall   = 1'b0;
			ctrl.mret    = 1'b0;
			ctrl.illegal = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  enable,	// Low while held
	input  decodePkg::fetchPkt_t  inFetch,
	input  logic                  exceptionPending,
	output decodePkg::decodeOut_t outDec
);

	decodePkg::fetchPkt_t  pktReg;	// Pipe register
	decodePkg::decodeOut_t ctrl;
	decodePkg::immFmt_t    fmt;
	decodePkg::word_t      imm;
	logic                  kill;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pktReg <= '0;
		else if (enable)
			pktReg <= inFetch;
	end

	// An empty slot decodes as a bubble too
	assign kill = exceptionPending || !pktReg.valid;

	instrDecoder u_instrDecoder (
		.instr            (pktReg.instr),
		.exceptionPending (kill),
		.ctrl             (ctrl),
		.fmt              (fmt)
	);

	immGen u_immGen (
		.instr (pktReg.instr),
		.fmt   (fmt),
		.imm   (imm)
	);

	always_comb
	begin
		outDec            = ctrl;
		outDec.valid      = pktReg.valid;
		outDec.pc         = pktReg.pc;
		outDec.rd         = decodePkg::regIdx_t'(pktReg.instr[11:7]);
		outDec.rs1        = decodePkg::regIdx_t'(pktReg.instr[19:15]);
		outDec.rs2        = decodePkg::regIdx_t'(pktReg.instr[24:20]);
		outDec.imm        = imm;
		outDec.csrAddr    = pktReg.instr[31:20];	// Same bits as funct12
		outDec.misaligned = pktReg.misaligned;
	end

	// Fetch keeps its packet while the stage is held, so none is lost
	assert property (@(posedge clk) disable iff (!nrst) !enable |=> $stable(inFetch))
		else $error("decodeStage: fetch packet changed while held");

endmodule

`default_nettype wire

//--- logic/decodeTop.sv
`timescale 1ns/1ns
`default_nettype none

module decodeTop (
	input  logic                  clk,
	input  logic                  nrst,
	input  decodePkg::fetchPkt_t  inFetch,
	input  logic                  stallReq,
	input  logic [1:0]            stallCycles,
	input  logic                  exceptionPending,	// Level from commit
	output logic                  hold,	// Back to fetch
	output decodePkg::decodeOut_t outDec
);

	logic       timerLoad;
	logic [1:0] timerValue;
	logic       timerDone;

	stallCtrl u_stallCtrl (
		.clk         (clk),
		.nrst        (nrst),
		.stallReq    (stallReq),
		.stallCycles (stallCycles),
		.timerDone   (timerDone),
		.timerLoad   (timerLoad),
		.timerValue  (timerValue),
		.hold        (hold)
	);

	holdTimer u_holdTimer (
		.clk       (clk),
		.nrst      (nrst),
		.load      (timerLoad),
		.loadValue (timerValue),
		.done      (timerDone)
	);

	// Register loads on every edge without hold
	decodeStage u_decodeStage (
		.clk              (clk),
		.nrst             (nrst),
		.enable           (!hold),
		.inFetch          (inFetch),
		.exceptionPending (exceptionPending),
		.outDec           (outDec)
	);

endmodule

`default_nettype wire

//--- tests/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected decode of one stored fetch packet, by the RV32IM encoding rules
function automatic decodePkg::decodeOut_t expectDecode(input decodePkg::fetchPkt_t pkt,
	input logic exc);
	decodePkg::decodeOut_t e;
	decodePkg::word_t      i;
	logic [2:0]            f3;
	logic [6:0]            f7;
	logic                  bad;	// Outside RV32IM
	i   = pkt.instr;
	f3  = i[14:12];
	f7  = i[31:25];
	bad = 1'b0;
	e   = '0;	// ADD, ALU unit, rs2 operand, sequential pc
	e.valid      = pkt.valid;
	e.pc         = pkt.pc;
	e.rd         = i[11:7];
	e.rs1        = i[19:15];
	e.rs2        = i[24:20];
	e.csrAddr    = i[31:20];
	e.funct3     = f3;
	e.misaligned = pkt.misaligned;
	case (i[6:0])
		decodePkg::OPC_LOAD:
		begin
			e.imm    = 32'($signed(i[31:20]));
			e.fnUnit = decodePkg::FU_LSU;
			e.bSel   = decodePkg::BSEL_IMM;
			e.we     = 1'b1;
			bad      = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
			if (!bad)
				e.memOp = {1'b0, f3[2], f3[1:0] + 2'd1};	// funct3[2] marks unsigned
		end
		decodePkg::OPC_STORE:
		begin
			e.imm    = 32'($signed({i[31:25], i[11:7]}));
			e.fnUnit = decodePkg::FU_LSU;
			e.bSel   = decodePkg::BSEL_IMM;
			bad      = (f3 > 3'd2);
			if (!bad)
				e.memOp = {2'b10, f3[1:0] + 2'd1};
		end
		decodePkg::OPC_OPIMM:
		begin
			e.imm   = 32'($signed(i[31:20]));
			e.bSel  = decodePkg::BSEL_IMM;
			e.we    = 1'b1;
			e.aluFn = {1'b0, f3};
			if (f3 == 3'd5)
			begin
				e.aluFn = {i[30], f3};	// Arithmetic shift bit
				bad     = !(f7 == 7'h00 || f7 == 7'h20);
			end
			else if (f3 == 3'd1)
				bad = (f7 != 7'h00);
		end
		decodePkg::OPC_OP:
		begin
			e.we    = 1'b1;
			e.aluFn = {i[30], f3};
			if (f7 == 7'h01)
			begin
				e.fnUnit   = decodePkg::FU_MULDIV;
				e.mulDivOp = f3;
			end
			else if (f7 == 7'h20)
				bad = !(f3 == 3'd0 || f3 == 3'd5);	// SUB and SRA only
			else
				bad = (f7 != 7'h00);
		end
		decodePkg::OPC_BRANCH:
		begin
			e.imm      = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
			e.fnUnit   = decodePkg::FU_BRANCH;
			e.branch   = 1'b1;
			e.pcSel    = decodePkg::PC_BRANCH;
			e.branchNe = f3[0];
			bad        = (f3[2:1] == 2'b01);
			if (!bad)
				e.aluFn = f3[2] ? {3'b001, f3[1]} : 4'b1000;	// Compare or subtract
		end
		decodePkg::OPC_JAL, decodePkg::OPC_JALR:
		begin
			e.fnUnit  = decodePkg::FU_BRANCH;
			e.jump    = 1'b1;
			e.pcSel   = decodePkg::PC_JUMP;
			e.bSel    = decodePkg::BSEL_FOUR;	// Link value
			e.we      = 1'b1;
			e.jumpReg = (i[6:0] == decodePkg::OPC_JALR);
			if (e.jumpReg)
			begin
				e.imm = 32'($signed(i[31:20]));
				bad   = (f3 != 3'd0);
			end
			else
				e.imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
		end
		decodePkg::OPC_LUI, decodePkg::OPC_AUIPC:
		begin
			e.imm   = {i[31:12], 12'h000};
			e.bSel  = decodePkg::BSEL_IMM;
			e.we    = 1'b1;
			e.lui   = (i[6:0] == decodePkg::OPC_LUI);
			e.auipc = !e.lui;
		end
		decodePkg::OPC_SYSTEM:
		begin
			e.system = 1'b1;
			e.fnUnit = decodePkg::FU_CSR;
			if (f3 == 3'd0)
			begin
				e.pcSel = decodePkg::PC_TRAP;
				e.ecall = (i[31:20] == 12'h000);
				e.mret  = (i[31:20] == 12'h302);
				bad     = !(e.ecall || e.mret);
			end
			else if (f3 == 3'd4)
				bad = 1'b1;	// No CSR op here
			else
				e.we = 1'b1;
		end
		default:
			bad = 1'b1;
	endcase
	e.illegal = bad;
	if (bad)
		e.we = 1'b0;
	// Empty slot or pending trap
	if (exc || !pkt.valid)
	begin
		e.we      = 1'b0;
		e.memOp   = 4'h0;
		e.fnUnit  = decodePkg::FU_ALU;
		e.pcSel   = decodePkg::PC_SEQ;
		e.system  = 1'b0;
		e.ecall   = 1'b0;
		e.mret    = 1'b0;
		e.illegal = 1'b0;
	end
	return e;
endfunction

// Hold cycles left after this edge
function automatic logic [1:0] nextHoldLeft(input logic [1:0] left, input logic req,
	input logic [1:0] cycles);
	if (left != 2'd0)
		return left - 2'd1;	// Requests inside a hold are dropped
	if (req)
		return cycles - 2'd1;
	return 2'd0;
endfunction

`endif

//--- tests/decodeTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeTb;

	localparam logic [31:0] SEED = 32'h65fd7e5f;
	localparam int N_BASE  = 400;	// Cycles per test
	localparam int N_MDRAW = 200;
	localparam int N_STALL = 300;
	localparam int N_EXC   = 200;
	localparam int N_SYS   = 200;
	localparam int RUN_LIMIT = 5 + N_BASE + N_MDRAW + N_STALL + N_EXC + N_SYS + 100;

	// Stimulus mixes
	localparam int M_BASE  = 0;
	localparam int M_MDRAW = 1;
	localparam int M_MIXED = 2;
	localparam int M_SYS   = 3;

	logic                  clk;
	logic                  nrst;
	decodePkg::fetchPkt_t  inFetch;
	logic                  stallReq;
	logic [1:0]            stallCycles;
	logic                  exceptionPending;
	logic                  hold;
	decodePkg::decodeOut_t outDec;

	logic [31:0]           rng;	// xorshift state
	decodePkg::fetchPkt_t  curPkt;	// On the fetch port
	decodePkg::fetchPkt_t  accPkt;	// Last taken with hold low
	logic                  accepted;
	logic [1:0]            holdLeft;
	logic                  prevHold;
	logic                  lastExc;
	decodePkg::decodeOut_t lastOut;	// Model result of the last cycle
	int                    passCount;
	int                    failCount;
	int                    testFails;	// failCount when the test began
	int                    cycleCount = 0;

	`include "decodeModel.svh"

	decodeTop u_decodeTop (
		.clk              (clk),
		.nrst             (nrst),
		.inFetch          (inFetch),
		.stallReq         (stallReq),
		.stallCycles      (stallCycles),
		.exceptionPending (exceptionPending),
		.hold             (hold),
		.outDec           (outDec)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= RUN_LIMIT)
		begin
			$display("Timeout, the test sequence ran past %0d cycles", RUN_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Template table over random fields or a raw word
	function automatic decodePkg::word_t makeInstr(input int mode);
		decodePkg::word_t w;
		logic [31:0]      r;
		int               kind;
		int               f;
		w = rand32();
		r = rand32();
		f = int'(r[15:8]);
		case (mode)
			M_BASE:  kind = int'(r[7:0] % 8'd9);
			M_MDRAW: kind = r[0] ? 9 : 11;
			M_SYS:   kind = 10;
			default: kind = (r[2:0] == 3'd0) ? 11 : int'(r[7:3] % 5'd11);	// 1 in 8 raw
		endcase
		case (kind)
			0:
			begin
				w[6:0]   = decodePkg::OPC_LOAD;
				w[14:12] = 3'(f % 5 < 3 ? f % 5 : f % 5 + 1);	// 0,1,2,4,5
			end
			1:
			begin
				w[6:0]   = decodePkg::OPC_STORE;
				w[14:12] = 3'(f % 3);
			end
			2:
			begin
				w[6:0] = decodePkg::OPC_OPIMM;
				if (w[14:12] == 3'd1)
					w[31:25] = 7'h00;	// SLLI
				else if (w[14:12] == 3'd5)
					w[31:25] = r[16] ? 7'h20 : 7'h00;
			end
			3:
			begin
				w[6:0]   = decodePkg::OPC_OP;
				w[31:25] = (r[16] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
			end
			4:
			begin
				w[6:0]   = decodePkg::OPC_BRANCH;
				w[14:12] = 3'(f % 6 < 2 ? f % 6 : f % 6 + 2);	// Skips 2 and 3
			end
			5:
				w[6:0] = decodePkg::OPC_JAL;
			6:
			begin
				w[6:0]   = decodePkg::OPC_JALR;
				w[14:12] = 3'd0;
			end
			7:
				w[6:0] = decodePkg::OPC_LUI;
			8:
				w[6:0] = decodePkg::OPC_AUIPC;
			9:
			begin
				w[6:0]   = decodePkg::OPC_OP;
				w[31:25] = 7'h01;	// M extension
			end
			10:
			begin
				if (f % 8 == 0)
					w = 32'h0000_0073;	// ecall
				else if (f % 8 == 1)
					w = 32'h3020_0073;	// mret
				else
				begin
					w[6:0]   = decodePkg::OPC_SYSTEM;
					w[14:12] = 3'(f % 8 < 5 ? f % 8 - 1 : f % 8);	// CSR ops
				end
			end
			default:
				w = w;	// Raw word
		endcase
		return w;
	endfunction

	function automatic decodePkg::fetchPkt_t newPkt(input int mode);
		decodePkg::fetchPkt_t p;
		logic [31:0]          r;
		r            = rand32();
		p.valid      = 1'b1;
		p.pc         = {r[31:2], 2'b00};
		p.instr      = makeInstr(mode);
		p.misaligned = (mode == M_SYS) && r[0];
		return p;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
			passCount++;
		else
		begin
			failCount++;
			$display("Fail %s expected %h got %h", name, expected, actual);
		end
	endtask

	// Drive at the falling edge and check just before the rising edge
	task automatic runCycle(input int mode, input logic req, input logic [1:0] cyc,
		input logic exc);
		decodePkg::decodeOut_t want;
		logic                  expHold;
		@(negedge clk);
		if (accepted)
			curPkt = newPkt(mode);	// Else fetch repeats the held packet
		inFetch          = curPkt;
		stallReq         = req;
		stallCycles      = cyc;
		exceptionPending = exc;
		expHold          = (holdLeft != 2'd0) || req;
		#3;
		want = expectDecode(accPkt, exc);
		checkValue("hold", 32'(expHold), 32'(hold));
		assert (outDec === want)
			passCount++;
		else
		begin
			failCount++;
			$display("Fail outDec expected %h got %h", want, outDec);
		end
		if (exc)
		begin
			checkValue("outDec.rd", 32'(want.rd), 32'(outDec.rd));
			checkValue("outDec.imm", want.imm, outDec.imm);
		end
		if (prevHold && exc == lastExc)
		begin
			assert (outDec === lastOut)
				passCount++;
			else
			begin
				failCount++;
				$display("outDec moved on although hold was high on the last edge");
			end
		end
		lastOut  = want;
		lastExc  = exc;
		prevHold = expHold;
		@(posedge clk);
		accepted = !expHold;
		if (accepted)
			accPkt = curPkt;
		holdLeft = nextHoldLeft(holdLeft, req, cyc);
	endtask

	task automatic finishTest(input string name);
		$display("Test %s finished with %0d errors", name, failCount - testFails);
		testFails = failCount;
	endtask

	initial
	begin
		logic [31:0] r;
		nrst             = 1'b0;
		inFetch          = '0;
		stallReq         = 1'b0;
		stallCycles      = 2'd1;	// Never zero
		exceptionPending = 1'b0;
		rng              = SEED;
		curPkt           = '0;
		accPkt           = '0;
		accepted         = 1'b1;
		holdLeft         = 2'd0;
		prevHold         = 1'b0;
		lastExc          = 1'b0;
		lastOut          = '0;
		passCount        = 0;
		failCount        = 0;
		testFails        = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		#3;
		checkValue("outDec.valid", 32'd0, 32'(outDec.valid));
		checkValue("outDec.we", 32'd0, 32'(outDec.we));
		checkValue("outDec.illegal", 32'd0, 32'(outDec.illegal));
		checkValue("hold", 32'd0, 32'(hold));
		finishTest("reset");
		repeat (N_BASE) runCycle(M_BASE, 1'b0, 2'd1, 1'b0);
		finishTest("rv32i");
		repeat (N_MDRAW) runCycle(M_MDRAW, 1'b0, 2'd1, 1'b0);
		finishTest("muldiv and raw words");
		repeat (N_STALL)
		begin
			r = rand32();
			runCycle(M_MIXED, r[1:0] == 2'd0, r[9:8] % 2'd3 + 2'd1, 1'b0);	// 1 to 3
		end
		finishTest("stall");
		repeat (N_EXC)
		begin
			r = rand32();
			runCycle(M_MIXED, 1'b0, 2'd1, r[3:2] != 2'd0);	// Mostly pending
		end
		finishTest("exception bubble");
		repeat (N_SYS) runCycle(M_SYS, 1'b0, 2'd1, 1'b0);
		finishTest("system and misaligned");
		$display("Checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
logic/decodePkg.sv
logic/holdTimer.sv
logic/stallCtrl.sv
logic/immGen.sv
logic/instrDecoder.sv
logic/decodeStage.sv
logic/decodeTop.sv
tests/decodeTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module decodeTb -f sim.f -o decodeSim &&
./obj_dir/decodeSim > sim.log 2>&1 ||
{ echo "build or simulation error, see sim.log"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
